//--- Makefile
TOP = tb_apb_i2c

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+100 | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

//--- apb_i2c_props.sv
`timescale 1ns/100ps
`default_nettype none

module apb_i2c_props
    import i2c_pkg::*;
(
    input wire             pclk,
    input wire             arst_n,
    input wire             busy,
    input wire             pready,
    input wire             scl_out,
    input wire             sda_out,
    input wire             sda_line,
    input wire i2c_state_e state
);

    int fail_cnt = 0;

    // Bus released outside a transfer
    idle_bus_high: assert property (@(posedge pclk) disable iff (!arst_n)
        !busy |-> (scl_out && sda_line))
        else begin
            $error("SCL or SDA low while the master is idle");
            fail_cnt++;
        end

    zero_wait: assert property (@(posedge pclk) disable iff (!arst_n) pready)
        else begin
            $error("pready low");
            fail_cnt++;
        end

    // SDA edge under high SCL is a START or STOP
    sda_stable_scl_high: assert property (@(posedge pclk) disable iff (!arst_n)
        (scl_out && $past(scl_out) && (sda_out != $past(sda_out)))
        |-> (state inside {START, STOP}))
        else begin
            $error("SDA changed with SCL high outside START and STOP");
            fail_cnt++;
        end

endmodule

bind apb_i2c_top apb_i2c_props props (
    .pclk     (pclk),
    .arst_n   (arst_n),
    .busy     (busy),
    .pready   (pready),
    .scl_out  (scl_out),
    .sda_out  (sda_out),
    .sda_line (sda_in),
    .state    (i2c_master_fsm.state)
);

`default_nettype wire

//--- apb_i2c_top.sv
`timescale 1ns/100ps
`default_nettype none

module apb_i2c_top
    import i2c_pkg::*;
    import apb_pkg::*;
(
    input  wire             pclk,
    input  wire             arst_n,
    input  wire             psel,
    input  wire             penable,
    input  wire             pwrite,
    input  wire apb_addr_t  paddr,
    input  wire byte_t      pwdata,
    input  wire             sda_in,
    output byte_t           prdata,
    output logic            pready,
    output logic            scl_out,
    output logic            sda_out
);

    apb_req_t  req;
    status_t   status;
    prescale_t prescale;
    byte_t     slave_addr;
    cmd_t      cmd;
    logic      go;

    // FIFO paths
    logic  tx_push;
    logic  tx_pop;
    byte_t tx_wdata;
    byte_t tx_head;
    logic  tx_full;
    logic  tx_empty;
    logic  rx_push;
    logic  rx_pop;
    byte_t rx_head;
    logic  rx_full;
    logic  rx_empty;

    // Bit engine
    logic  qtick;
    logic  tmr_run;
    logic  load;
    byte_t load_data;
    logic  shift;
    logic  sample;
    logic  sda_bit;
    byte_t rx_byte;
    logic  busy;
    logic  nack;

    assign req = '{psel: psel, penable: penable, pwrite: pwrite,
                   paddr: paddr, pwdata: pwdata};

    assign status = '{busy: busy, nack: nack, tx_full: tx_full, tx_empty: tx_empty,
                      rx_full: rx_full, rx_empty: rx_empty};

    apb_regs apb_regs (.*);

    byte_fifo tx_fifo (
        .pclk   (pclk),
        .arst_n (arst_n),
        .push   (tx_push),
        .wdata  (tx_wdata),
        .pop    (tx_pop),
        .rdata  (tx_head),
        .full   (tx_full),
        .empty  (tx_empty)
    );

    byte_fifo rx_fifo (
        .pclk   (pclk),
        .arst_n (arst_n),
        .push   (rx_push),
        .wdata  (rx_byte),
        .pop    (rx_pop),
        .rdata  (rx_head),
        .full   (rx_full),
        .empty  (rx_empty)
    );

    scl_timer scl_timer (
        .run    (tmr_run),
        .*
    );

    i2c_shifter i2c_shifter (.*);

    i2c_master_fsm i2c_master_fsm (.*);

endmodule

`default_nettype wire

//--- apb_pkg.sv
`default_nettype none

package apb_pkg;

    import i2c_pkg::*;

    typedef logic [7:0] apb_addr_t;

    localparam apb_addr_t ADDR_PRESCALE = 8'd0;
    localparam apb_addr_t ADDR_CMD      = 8'd1;
    localparam apb_addr_t ADDR_STATUS   = 8'd2;
    localparam apb_addr_t ADDR_TXDATA   = 8'd3;
    localparam apb_addr_t ADDR_RXDATA   = 8'd4;
    localparam apb_addr_t ADDR_SLAVE    = 8'd5;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        byte_t     pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

//--- apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module apb_regs
    import i2c_pkg::*;
    import apb_pkg::*;
(
    input  wire            pclk,
    input  wire            arst_n,
    input  wire apb_req_t  req,
    input  wire status_t   status,
    input  wire byte_t     rx_head,
    output byte_t          prdata,
    output logic           pready,
    output prescale_t      prescale,
    output byte_t          slave_addr,
    output cmd_t           cmd,
    output logic           go,
    output logic           tx_push,
    output byte_t          tx_wdata,
    output logic           rx_pop
);

    logic access;
    logic wr_en;
    cmd_t wr_cmd;

    // ACCESS phase, zero wait states
    assign access = req.psel && req.penable;
    assign wr_en  = access && req.pwrite;
    assign pready = 1'b1;

    assign wr_cmd = cmd_t'(req.pwdata[$bits(cmd_t)-1:0]);

    assign tx_push  = wr_en && (req.paddr == ADDR_TXDATA);
    assign tx_wdata = req.pwdata;
    assign rx_pop   = access && !req.pwrite && (req.paddr == ADDR_RXDATA);

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            prescale   <= '0;
            slave_addr <= '0;
            cmd        <= '0;
            go         <= 1'b0;
        end else begin
            go <= 1'b0;
            if (wr_en) begin
                case (req.paddr)
                    ADDR_PRESCALE: prescale <= req.pwdata;
                    ADDR_CMD: begin
                        cmd <= wr_cmd;
                        go  <= wr_cmd.start;
                    end
                    ADDR_SLAVE: slave_addr <= req.pwdata;
                    default: ;
                endcase
            end
        end
    end

    // RX head is shown before the pop takes effect
    always_comb begin
        case (req.paddr)
            ADDR_PRESCALE: prdata = prescale;
            ADDR_CMD:      prdata = {2'b00, cmd};
            ADDR_STATUS:   prdata = {2'b00, status};
            ADDR_RXDATA:   prdata = rx_head;
            ADDR_SLAVE:    prdata = slave_addr;
            default:       prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module byte_fifo
    import i2c_pkg::*;
(
    input  wire         pclk,
    input  wire         arst_n,
    input  wire         push,
    input  wire byte_t  wdata,
    input  wire         pop,
    output byte_t       rdata,
    output logic        full,
    output logic        empty
);

    // Extra MSB tells a full buffer from an empty one
    typedef logic [$clog2(FIFO_DEPTH):0] ptr_t;

    byte_t mem [FIFO_DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[$bits(ptr_t)-1] != rd_ptr[$bits(ptr_t)-1]) &&
                   (wr_ptr[$bits(ptr_t)-2:0] == rd_ptr[$bits(ptr_t)-2:0]);

    assign rdata = mem[rd_ptr[$bits(ptr_t)-2:0]];

    always_ff @(posedge pclk) begin
        if (push && !full) begin
            mem[wr_ptr[$bits(ptr_t)-2:0]] <= wdata;
        end
    end

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- i2c_master_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_master_fsm
    import i2c_pkg::*;
(
    input  wire         pclk,
    input  wire         arst_n,
    input  wire         go,
    input  wire cmd_t   cmd,
    input  wire byte_t  slave_addr,
    input  wire         qtick,
    input  wire         sda_in,
    input  wire         sda_bit,
    input  wire byte_t  rx_byte,
    input  wire byte_t  tx_head,
    input  wire         tx_empty,
    output logic        tmr_run,
    output logic        load,
    output byte_t       load_data,
    output logic        shift,
    output logic        sample,
    output logic        tx_pop,
    output logic        rx_push,
    output logic        scl_out,
    output logic        sda_out,
    output logic        busy,
    output logic        nack
);

    i2c_state_e state;
    logic [1:0] qtr;
    bit_cnt_t   bit_cnt;
    len_t       byte_cnt;
    cmd_t       cur_cmd;

    logic bit_end;
    logic ack_slot;
    logic last_byte;
    logic to_write;

    assign bit_end   = qtick && (qtr == 2'd3);
    assign ack_slot  = (state == ADDR_ACK) || (state == WRITE_ACK);
    assign last_byte = (byte_cnt >= cur_cmd.len);

    // ACK bit sits in rx_byte[0] by the end of the slot
    assign to_write = bit_end && ack_slot && !rx_byte[0] && !tx_empty &&
                      !((state == ADDR_ACK) && cur_cmd.rw);

    assign busy    = (state != IDLE);
    assign tmr_run = busy;

    assign load      = (bit_end && state == START) || to_write;
    assign load_data = (state == START) ? {slave_addr[6:0], cur_cmd.rw} : tx_head;
    assign tx_pop    = to_write;
    assign shift     = bit_end && ((state == ADDR) || (state == WRITE));
    assign sample    = qtick && (qtr == 2'd1) && (ack_slot || state == READ);
    assign rx_push   = bit_end && (state == READ) && (bit_cnt == 4'd7);

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            qtr      <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            cur_cmd  <= '0;
            nack     <= 1'b0;
        end else begin
            if (qtick) begin
                qtr <= qtr + 1'b1;
            end
            if (bit_end) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    // Start only on a free bus
                    if (go && sda_in) begin
                        state    <= START;
                        cur_cmd  <= cmd;
                        nack     <= 1'b0;
                        byte_cnt <= '0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state   <= ADDR;
                        bit_cnt <= '0;
                    end
                end
                ADDR: begin
                    if (bit_end && bit_cnt == 4'd7) begin
                        state <= ADDR_ACK;
                    end
                end
                ADDR_ACK, WRITE_ACK: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (rx_byte[0]) begin
                            nack  <= 1'b1;
                            state <= STOP;
                        end else if (state == ADDR_ACK && cur_cmd.rw) begin
                            state <= READ;
                        end else if (to_write) begin
                            state <= WRITE;
                        end else begin
                            state <= STOP;
                        end
                    end
                end
                WRITE: begin
                    if (bit_end && bit_cnt == 4'd7) begin
                        state <= WRITE_ACK;
                    end
                end
                READ: begin
                    if (bit_end && bit_cnt == 4'd7) begin
                        state    <= READ_ACK;
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                READ_ACK: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        state   <= last_byte ? STOP : READ;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // SCL high in quarters 1 and 2 of a data bit
    always_comb begin
        case (state)
            IDLE:    scl_out = 1'b1;
            START:   scl_out = (qtr != 2'd3);
            STOP:    scl_out = (qtr != 2'd0);
            default: scl_out = (qtr == 2'd1) || (qtr == 2'd2);
        endcase
    end

    // SDA edges with SCL high only in START and STOP
    always_comb begin
        case (state)
            START:         sda_out = (qtr < 2'd2);
            STOP:          sda_out = (qtr >= 2'd2);
            ADDR, WRITE:   sda_out = sda_bit;
            READ_ACK:      sda_out = last_byte;
            default:       sda_out = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    localparam int FIFO_DEPTH = 8;

    typedef logic [7:0] byte_t;
    // pclk cycles per quarter bit, minus one
    typedef logic [7:0] prescale_t;
    // Data bits plus the ACK slot
    typedef logic [3:0] bit_cnt_t;
    typedef logic [3:0] len_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        ADDR_ACK,
        WRITE,
        WRITE_ACK,
        READ,
        READ_ACK,
        STOP
    } i2c_state_e;

    // CMD register layout, bit 5 down to bit 0
    typedef struct packed {
        logic start;
        logic rw;
        len_t len;
    } cmd_t;

    // STATUS register layout, bit 5 down to bit 0
    typedef struct packed {
        logic busy;
        logic nack;
        logic tx_full;
        logic tx_empty;
        logic rx_full;
        logic rx_empty;
    } status_t;

endpackage

`default_nettype wire

//--- i2c_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_shifter
    import i2c_pkg::*;
(
    input  wire         pclk,
    input  wire         arst_n,
    input  wire         load,
    input  wire byte_t  load_data,
    input  wire         shift,
    input  wire         sample,
    input  wire         sda_in,
    output logic        sda_bit,
    output byte_t       rx_byte
);

    byte_t tx_sr;
    byte_t rx_sr;

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            tx_sr <= '1;
            rx_sr <= '0;
        end else begin
            if (load) begin
                tx_sr <= load_data;
            end else if (shift) begin
                // Fill with ones so the line is released when idle
                tx_sr <= {tx_sr[6:0], 1'b1};
            end
            if (sample) begin
                rx_sr <= {rx_sr[6:0], sda_in};
            end
        end
    end

    assign sda_bit = tx_sr[7];
    assign rx_byte = rx_sr;

endmodule

`default_nettype wire

//--- scl_timer.sv
`timescale 1ns/100ps
`default_nettype none

module scl_timer
    import i2c_pkg::*;
(
    input  wire             pclk,
    input  wire             arst_n,
    input  wire             run,
    input  wire prescale_t  prescale,
    output logic            qtick
);

    prescale_t cnt;

    // Held at the reload value while idle
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (!run || cnt == '0) begin
            cnt <= prescale;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    assign qtick = run && (cnt == '0);

endmodule

`default_nettype wire

//--- src.f
i2c_pkg.sv
apb_pkg.sv
byte_fifo.sv
scl_timer.sv
i2c_shifter.sv
i2c_master_fsm.sv
apb_regs.sv
apb_i2c_top.sv
apb_i2c_props.sv
tb_apb_i2c.sv

//--- tb_apb_i2c.sv
`timescale 1ns/100ps
`default_nettype none

module tb_apb_i2c
    import i2c_pkg::*;
    import apb_pkg::*;
();

    localparam int    CLK_NS   = 100;
    localparam byte_t SLAVE_ID = 8'h2A;

    logic      pclk;
    logic      arst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    byte_t     pwdata;
    byte_t     prdata;
    logic      pready;
    logic      scl_out;
    logic      sda_out;

    int errors;
    int timeouts;

    // I2C slave model state
    logic  slave_sda;
    logic  sda_line;
    logic  prev_scl;
    logic  prev_sda;
    logic  active;
    logic  rd;
    logic  ack_bit;
    int    bit_i;
    int    byte_i;
    int    stops;
    byte_t shreg;
    byte_t tx_sh;
    byte_t addr_seen;
    byte_t lfsr_state;
    byte_t wr_q[$];
    byte_t sent_q[$];
    byte_t exp_q[$];
    logic  mack_q[$];
    time   rise_t[8];

    // Open drain where low wins
    assign sda_line = sda_out & slave_sda;

    apb_i2c_top UUT (
        .pclk    (pclk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .sda_in  (sda_line),
        .prdata  (prdata),
        .pready  (pready),
        .scl_out (scl_out),
        .sda_out (sda_out)
    );

    initial begin
        pclk = 1'b0;
        forever #(CLK_NS / 2) pclk = ~pclk;
    end

    // Galois form with taps 8 6 5 4 and the LSB as the bit taken
    function automatic byte_t lfsr_step(input byte_t s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    function automatic byte_t take_random_byte();
        byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return b;
    endfunction

    // Sampled mid-cycle away from the master's edges
    always @(negedge pclk) begin
        if (prev_scl && scl_out && prev_sda && !sda_line) begin
            active = 1'b1;
            rd     = 1'b0;
            bit_i  = 0;
            byte_i = 0;
            shreg  = '0;
        end else if (prev_scl && scl_out && !prev_sda && sda_line) begin
            active = 1'b0;
            stops++;
        end else if (active && !prev_scl && scl_out) begin
            if (bit_i < 8) begin
                shreg = {shreg[6:0], sda_line};
                if (byte_i == 0) begin
                    rise_t[bit_i] = $time;
                end
            end else begin
                ack_bit = sda_line;
                if (rd && byte_i > 0) begin
                    mack_q.push_back(sda_line);
                end
            end
            bit_i++;
        end else if (active && prev_scl && !scl_out) begin
            if (bit_i == 8) begin
                if (byte_i == 0) begin
                    addr_seen = shreg;
                    rd        = shreg[0];
                    slave_sda = (shreg[7:1] != SLAVE_ID[6:0]);
                end else if (!rd) begin
                    wr_q.push_back(shreg);
                    slave_sda = 1'b0;
                end else begin
                    slave_sda = 1'b1;
                end
            end else if (bit_i == 9) begin
                bit_i = 0;
                byte_i++;
                if (rd && !ack_bit) begin
                    tx_sh = take_random_byte();
                    sent_q.push_back(tx_sh);
                    slave_sda = tx_sh[7];
                    tx_sh     = tx_sh << 1;
                end else begin
                    slave_sda = 1'b1;
                end
            end else if (rd && byte_i > 0) begin
                slave_sda = tx_sh[7];
                tx_sh     = tx_sh << 1;
            end
        end
        prev_scl = scl_out;
        prev_sda = sda_line;
    end

    task automatic check_eq(input string what, input byte_t got, input byte_t exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            errors++;
            $display("ERROR %0d ns: %s does not hold", $time, what);
        end
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, input byte_t wdata,
                              output byte_t rdata);
        int n;
        @(posedge pclk);
        #10;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge pclk);
        #10;
        penable = 1'b1;
        n = 0;
        @(negedge pclk);
        while (!pready && n < 16) begin
            n++;
            @(negedge pclk);
        end
        if (!pready) begin
            timeouts++;
            $display("Timeout: pready stayed low on an access to address %0d", addr);
        end
        rdata = prdata;
        @(posedge pclk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input byte_t data);
        byte_t unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output byte_t data);
        apb_access(1'b0, addr, 8'h00, data);
    endtask

    task automatic read_status(output status_t st);
        byte_t d;
        apb_read(ADDR_STATUS, d);
        st = status_t'(d[$bits(status_t)-1:0]);
    endtask

    task automatic start_transfer(input logic rw, input len_t len);
        cmd_t c;
        c = '{start: 1'b1, rw: rw, len: len};
        apb_write(ADDR_CMD, byte_t'(c));
    endtask

    task automatic wait_idle();
        status_t st;
        int n;
        n = 0;
        read_status(st);
        while (st.busy && n < 5000) begin
            n++;
            read_status(st);
        end
        if (st.busy) begin
            timeouts++;
            $display("Timeout: transfer still busy after %0d status polls", n);
        end
    endtask

    task automatic clear_capture();
        wr_q.delete();
        sent_q.delete();
        mack_q.delete();
        stops     = 0;
        addr_seen = '0;
    endtask

    task automatic check_written_bytes();
        check_true("write byte count", wr_q.size() == exp_q.size());
        for (int i = 0; i < exp_q.size() && i < wr_q.size(); i++) begin
            check_eq("written byte", wr_q[i], exp_q[i]);
        end
    endtask

    // SCL rising edges of the address byte
    task automatic check_bit_period(input prescale_t p);
        time exp_t;
        exp_t = 4 * (p + 1) * CLK_NS;
        for (int i = 1; i < 8; i++) begin
            assert (rise_t[i] - rise_t[i-1] == exp_t) else begin
                errors++;
                $display("ERROR %0d ns: SCL period is %0d ns, expected %0d ns",
                         $time, rise_t[i] - rise_t[i-1], exp_t);
            end
        end
    endtask

    initial begin
        status_t st;
        byte_t   d;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        slave_sda  = 1'b1;
        prev_scl   = 1'b1;
        prev_sda   = 1'b1;
        active     = 1'b0;
        rd         = 1'b0;
        ack_bit    = 1'b1;
        lfsr_state = 8'd90;
        errors     = 0;
        timeouts   = 0;
        clear_capture();
        arst_n = 1'b0;
        repeat (8) @(posedge pclk);
        #10;
        arst_n = 1'b1;

        read_status(st);
        check_true("busy clear after reset", !st.busy);
        check_true("TX empty after reset", st.tx_empty);
        check_true("RX empty after reset", st.rx_empty);
        apb_write(ADDR_PRESCALE, 8'd4);
        apb_write(ADDR_SLAVE, SLAVE_ID);
        apb_read(ADDR_PRESCALE, d);
        check_eq("PRESCALE readback", d, 8'd4);
        apb_read(ADDR_SLAVE, d);
        check_eq("SLAVE readback", d, SLAVE_ID);

        // Three byte write
        clear_capture();
        exp_q = '{8'hA5, 8'h3C, 8'h81};
        foreach (exp_q[i]) apb_write(ADDR_TXDATA, exp_q[i]);
        start_transfer(1'b0, 4'd0);
        wait_idle();
        check_eq("write address byte", addr_seen, 8'h54);
        check_written_bytes();
        read_status(st);
        check_true("TX empty after write", st.tx_empty);
        check_true("no NACK on write", !st.nack);
        check_true("STOP after write", stops == 1);
        check_bit_period(8'd4);

        // Four byte read with NACK on the last
        clear_capture();
        start_transfer(1'b1, 4'd4);
        wait_idle();
        check_eq("read address byte", addr_seen, 8'h55);
        check_true("slave sent four bytes", sent_q.size() == 4);
        for (int i = 0; i < 4; i++) begin
            apb_read(ADDR_RXDATA, d);
            if (i < sent_q.size()) begin
                check_eq("RXDATA", d, sent_q[i]);
            end
        end
        check_true("master ACK count", mack_q.size() == 4);
        for (int i = 0; i < mack_q.size(); i++) begin
            check_true("master ACK bit", mack_q[i] == (i == 3));
        end

        // Full TX FIFO drops a ninth push
        clear_capture();
        exp_q.delete();
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            exp_q.push_back(byte_t'(i * 37 + 5));
            apb_write(ADDR_TXDATA, exp_q[i]);
        end
        read_status(st);
        check_true("TX full after eight pushes", st.tx_full);
        apb_write(ADDR_TXDATA, 8'hEE);
        start_transfer(1'b0, 4'd0);
        wait_idle();
        check_written_bytes();

        // Address NACK
        clear_capture();
        apb_write(ADDR_PRESCALE, 8'd1);
        apb_write(ADDR_SLAVE, 8'h11);
        apb_write(ADDR_TXDATA, 8'h77);
        start_transfer(1'b0, 4'd0);
        wait_idle();
        read_status(st);
        check_true("NACK flag set", st.nack);
        check_eq("NACK address byte", addr_seen, 8'h22);
        check_true("no data after NACK", wr_q.size() == 0);
        check_true("bus high after NACK", scl_out && sda_line);
        check_bit_period(8'd1);

        $display("Checks done: %0d errors, %0d timeouts, %0d property failures",
                 errors, timeouts, UUT.props.fail_cnt);
        if (errors == 0 && timeouts == 0 && UUT.props.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
